// ==== design/tart_pkg.sv ====
`default_nettype none

package tart_pkg;

   // --------------------
   // Array defaults
   // --------------------

   // Number of one-bit antenna streams
   parameter int ANTENNAS_DEF = 4;

   // Width of the pair counters and of the block size
   parameter int ACCUM_DEF    = 16;   // Blocks up to 65535 samples

   // --------------------
   // Capture settings
   // --------------------

   // Sample delay field, so delays of 0 to 7 samples
   parameter int DELAY_BITS   = 3;

   // --------------------
   // Visibility bank
   // --------------------

   // Occupancy of one block buffer
   typedef enum logic {
      BANK_FREE = 1'b0,   // Can take the next block
      BANK_FULL = 1'b1    // Holds a block not yet released
   } bank_state_e;

endpackage : tart_pkg

`default_nettype wire

// ==== design/ax_capture.sv ====
`default_nettype none

module ax_capture #(
   parameter int ANTENNAS = tart_pkg::ANTENNAS_DEF
) (
   input  logic                            b_clk,
   input  logic                            reset_i,
   input  logic                            aq_enable_i,
   input  logic [tart_pkg::DELAY_BITS-1:0] aq_delay_i,
   input  logic [ANTENNAS-1:0]             antenna_i,
   output logic                            cap_valid_o,
   output logic [ANTENNAS-1:0]             cap_bits_o
);
   import tart_pkg::*;

   localparam int HIST_DEPTH = 1 << DELAY_BITS;   // One tap per delay setting

   logic [ANTENNAS-1:0] hist_q [HIST_DEPTH-1];    // Antenna bits 1 to 7 cycles back
   logic [ANTENNAS-1:0] tap_w  [HIST_DEPTH];      // Tap 0 is the live input

   // --------------------
   // Delay line
   // --------------------
   always_comb begin
      tap_w[0] = antenna_i;   // Zero delay
      for (int k = 1; k < HIST_DEPTH; k++) begin
         tap_w[k] = hist_q[k-1];
      end
   end

   // Shifts every cycle, enable or not
   always_ff @(posedge b_clk) begin
      hist_q[0] <= antenna_i;
      for (int k = 1; k < HIST_DEPTH-1; k++) begin
         hist_q[k] <= hist_q[k-1];
      end
   end

   // --------------------
   // Sample register
   // --------------------
   always_ff @(posedge b_clk) begin
      if (reset_i) begin
         cap_valid_o <= 1'b0;
      end else begin
         cap_valid_o <= aq_enable_i;   // Enable itself is not delayed
      end
   end

   // Delay moves the sampling point against the enable window
   always_ff @(posedge b_clk) begin
      cap_bits_o <= tap_w[aq_delay_i];
   end

   // Unknown delay bits select no history entry
   assert property (@(posedge b_clk) disable iff (reset_i)
      !$isunknown(aq_delay_i))
      else $error("ax_capture: delay index %0h unknown", aq_delay_i);

endmodule : ax_capture

`default_nettype wire

// ==== design/vis_correlate.sv ====
`default_nettype none

module vis_correlate #(
   parameter  int ANTENNAS = tart_pkg::ANTENNAS_DEF,
   localparam int NPAIR    = ANTENNAS*(ANTENNAS-1)/2
) (
   input  logic                b_clk,
   input  logic                reset_i,
   input  logic                cap_valid_i,
   input  logic [ANTENNAS-1:0] cap_bits_i,
   output logic                cor_valid_o,
   output logic [NPAIR-1:0]    cor_bits_o
);

   logic [NPAIR-1:0] agree_w;   // One agreement bit per pair

   // --------------------
   // Pair table
   // --------------------
   // Pairs (i, j) with i < j, row-major
   for (genvar i = 0; i < ANTENNAS-1; i++) begin : g_row
      for (genvar j = i+1; j < ANTENNAS; j++) begin : g_col
         // Row i starts after the pairs of all earlier rows
         localparam int P = i*(2*ANTENNAS-i-1)/2 + (j-i-1);

         assign agree_w[P] = ~(cap_bits_i[i] ^ cap_bits_i[j]);   // Equal signs
      end
   end

   // --------------------
   // Output register
   // --------------------
   always_ff @(posedge b_clk) begin
      if (reset_i) begin
         cor_valid_o <= 1'b0;
      end else begin
         cor_valid_o <= cap_valid_i;
      end
   end

   // Bits travel alongside the valid
   always_ff @(posedge b_clk) begin
      cor_bits_o <= agree_w;
   end

endmodule : vis_correlate

`default_nettype wire

// ==== design/vis_accumulate.sv ====
`default_nettype none

module vis_accumulate #(
   parameter  int ANTENNAS = tart_pkg::ANTENNAS_DEF,
   parameter  int ACCUM    = tart_pkg::ACCUM_DEF,
   localparam int NPAIR    = ANTENNAS*(ANTENNAS-1)/2
) (
   input  logic                   b_clk,
   input  logic                   reset_i,
   input  logic [ACCUM-1:0]       block_size_i,
   input  logic                   cor_valid_i,
   input  logic [NPAIR-1:0]       cor_bits_i,
   output logic                   blk_strobe_o,
   output logic [NPAIR*ACCUM-1:0] blk_counts_o
);

   logic [ACCUM-1:0] acc_q     [NPAIR];   // Running agreement counts
   logic [ACCUM-1:0] acc_nxt_w [NPAIR];   // Counts including this sample
   logic [ACCUM-1:0] smp_cnt_q;           // Valid samples so far in block
   logic [ACCUM-1:0] smp_nxt_w;
   logic [ACCUM-1:0] size_q;              // Block size held for the block
   logic [ACCUM-1:0] size_w;
   logic             first_w;
   logic             last_w;

   // --------------------
   // Block framing
   // --------------------
   assign first_w   = (smp_cnt_q == '0);
   assign size_w    = first_w ? block_size_i : size_q;   // Live value on first sample
   assign smp_nxt_w = smp_cnt_q + 1'b1;
   assign last_w    = cor_valid_i && (smp_nxt_w == size_w);

   always_comb begin
      for (int p = 0; p < NPAIR; p++) begin
         acc_nxt_w[p] = acc_q[p] + {{(ACCUM-1){1'b0}}, cor_bits_i[p]};
      end
   end

   // --------------------
   // Counters
   // --------------------
   always_ff @(posedge b_clk) begin
      if (reset_i) begin
         smp_cnt_q    <= '0;
         blk_strobe_o <= 1'b0;
         for (int p = 0; p < NPAIR; p++) begin
            acc_q[p] <= '0;
         end
      end else begin
         blk_strobe_o <= last_w;   // One cycle after the last valid
         if (cor_valid_i) begin
            if (last_w) begin
               smp_cnt_q <= '0;   // Next block starts clean
               for (int p = 0; p < NPAIR; p++) begin
                  acc_q[p] <= '0;
               end
            end else begin
               smp_cnt_q <= smp_nxt_w;
               acc_q     <= acc_nxt_w;
            end
         end
      end
   end

   // Size capture and finished block, packed pair 0 in the low bits
   always_ff @(posedge b_clk) begin
      if (cor_valid_i && first_w) begin
         size_q <= block_size_i;
      end
      if (last_w) begin
         for (int p = 0; p < NPAIR; p++) begin
            blk_counts_o[p*ACCUM +: ACCUM] <= acc_nxt_w[p];
         end
      end
   end

   // A zero size would keep the block open forever
   assert property (@(posedge b_clk) disable iff (reset_i)
      cor_valid_i |-> (size_w != '0))
      else $error("vis_accumulate: zero block size with valid sample");

endmodule : vis_accumulate

`default_nettype wire

// ==== design/vis_bank.sv ====
`default_nettype none

module vis_bank #(
   parameter  int ANTENNAS = tart_pkg::ANTENNAS_DEF,
   parameter  int ACCUM    = tart_pkg::ACCUM_DEF,
   localparam int NPAIR    = ANTENNAS*(ANTENNAS-1)/2,
   localparam int PBITS    = (NPAIR > 1) ? $clog2(NPAIR) : 1
) (
   input  logic                   b_clk,
   input  logic                   reset_i,
   input  logic                   blk_strobe_i,
   input  logic [NPAIR*ACCUM-1:0] blk_counts_i,
   input  logic                   rd_stb_i,
   input  logic [PBITS-1:0]       rd_adr_i,
   input  logic                   release_i,
   output logic [ACCUM-1:0]       rd_dat_o,
   output logic                   rd_ack_o,
   output logic                   available_o,
   output logic                   overflow_o
);
   import tart_pkg::*;

   logic [NPAIR*ACCUM-1:0] buf_q   [2];   // Two block buffers
   bank_state_e            state_q [2];
   logic                   wr_ptr_q;      // Next buffer to fill
   logic                   rd_ptr_q;      // Oldest full buffer
   logic                   wr_ok_w;
   logic                   rel_ok_w;
   logic                   avail_w;
   logic [NPAIR*ACCUM-1:0] rd_blk_w;

   // --------------------
   // Buffer queue
   // --------------------
   // Buffers fill and drain in turn, so wr_ptr is free if either is
   assign wr_ok_w  = blk_strobe_i && (state_q[wr_ptr_q] == BANK_FREE);
   assign rel_ok_w = release_i && (state_q[rd_ptr_q] == BANK_FULL);

   // After a release only the other buffer can still be full
   assign avail_w = rel_ok_w ? (state_q[!rd_ptr_q] == BANK_FULL)
                             : (state_q[rd_ptr_q] == BANK_FULL);

   always_ff @(posedge b_clk) begin
      if (reset_i) begin
         state_q[0]  <= BANK_FREE;
         state_q[1]  <= BANK_FREE;
         wr_ptr_q    <= 1'b0;
         rd_ptr_q    <= 1'b0;
         rd_ack_o    <= 1'b0;
         available_o <= 1'b0;
         overflow_o  <= 1'b0;
      end else begin
         rd_ack_o    <= rd_stb_i;
         available_o <= avail_w;   // Lags a fill by one cycle
         if (wr_ok_w) begin
            state_q[wr_ptr_q] <= BANK_FULL;
            wr_ptr_q          <= !wr_ptr_q;
         end else if (blk_strobe_i) begin
            overflow_o <= 1'b1;   // Block dropped, sticky
         end
         // Never the buffer being written
         if (rel_ok_w) begin
            state_q[rd_ptr_q] <= BANK_FREE;
            rd_ptr_q          <= !rd_ptr_q;
         end
      end
   end

   // --------------------
   // Storage and readback
   // --------------------
   assign rd_blk_w = buf_q[rd_ptr_q];

   always_ff @(posedge b_clk) begin
      if (wr_ok_w) begin
         buf_q[wr_ptr_q] <= blk_counts_i;
      end
      if (rd_stb_i) begin
         if (int'(rd_adr_i) < NPAIR) begin
            rd_dat_o <= rd_blk_w[rd_adr_i*ACCUM +: ACCUM];
         end else begin
            rd_dat_o <= '0;   // Past the last pair
         end
      end
   end

   // Readback only once a finished block is visible
   assert property (@(posedge b_clk) disable iff (reset_i)
      rd_stb_i |-> available_o)
      else $error("vis_bank: rd_stb_i with no block available");

   assert property (@(posedge b_clk) disable iff (reset_i)
      release_i |-> available_o)
      else $error("vis_bank: release_i with no block available");

endmodule : vis_bank

`default_nettype wire

// ==== design/tart_vis_top.sv ====
`default_nettype none

module tart_vis_top #(
   parameter  int ANTENNAS = tart_pkg::ANTENNAS_DEF,
   parameter  int ACCUM    = tart_pkg::ACCUM_DEF,
   localparam int NPAIR    = ANTENNAS*(ANTENNAS-1)/2,
   localparam int PBITS    = (NPAIR > 1) ? $clog2(NPAIR) : 1
) (
   input  logic                            b_clk,
   input  logic                            reset_i,
   input  logic                            aq_enable_i,
   input  logic [tart_pkg::DELAY_BITS-1:0] aq_delay_i,
   input  logic [ACCUM-1:0]                block_size_i,
   input  logic [ANTENNAS-1:0]             antenna_i,
   input  logic                            rd_stb_i,
   input  logic [PBITS-1:0]                rd_adr_i,
   input  logic                            release_i,
   output logic [ACCUM-1:0]                rd_dat_o,
   output logic                            rd_ack_o,
   output logic                            available_o,
   output logic                            overflow_o
);

   // --------------------
   // Stage links
   // --------------------
   logic                   cap_valid;
   logic [ANTENNAS-1:0]    cap_bits;     // Delayed antenna sample
   logic                   cor_valid;
   logic [NPAIR-1:0]       cor_bits;     // Pair agreement bits
   logic                   blk_strobe;
   logic [NPAIR*ACCUM-1:0] blk_counts;   // Finished block

   // Capture, one cycle
   ax_capture #(.ANTENNAS(ANTENNAS)) i_ax_capture (
      .b_clk       (b_clk),
      .reset_i     (reset_i),
      .aq_enable_i (aq_enable_i),
      .aq_delay_i  (aq_delay_i),
      .antenna_i   (antenna_i),
      .cap_valid_o (cap_valid),
      .cap_bits_o  (cap_bits)
   );

   vis_correlate #(.ANTENNAS(ANTENNAS)) i_vis_correlate (
      .b_clk       (b_clk),
      .reset_i     (reset_i),
      .cap_valid_i (cap_valid),
      .cap_bits_i  (cap_bits),
      .cor_valid_o (cor_valid),
      .cor_bits_o  (cor_bits)
   );

   vis_accumulate #(.ANTENNAS(ANTENNAS), .ACCUM(ACCUM)) i_vis_accumulate (
      .b_clk        (b_clk),
      .reset_i      (reset_i),
      .block_size_i (block_size_i),
      .cor_valid_i  (cor_valid),
      .cor_bits_i   (cor_bits),
      .blk_strobe_o (blk_strobe),
      .blk_counts_o (blk_counts)
   );

   // Double buffer and readback port
   vis_bank #(.ANTENNAS(ANTENNAS), .ACCUM(ACCUM)) i_vis_bank (
      .b_clk        (b_clk),
      .reset_i      (reset_i),
      .blk_strobe_i (blk_strobe),
      .blk_counts_i (blk_counts),
      .rd_stb_i     (rd_stb_i),
      .rd_adr_i     (rd_adr_i),
      .release_i    (release_i),
      .rd_dat_o     (rd_dat_o),
      .rd_ack_o     (rd_ack_o),
      .available_o  (available_o),
      .overflow_o   (overflow_o)
   );

endmodule : tart_vis_top

`default_nettype wire

// ==== verif/tb_clkgen.sv ====
`default_nettype none

module tb_clkgen #(
   parameter int PERIOD_NS    = 40,
   parameter int RESET_CYCLES = 10
) (
   output logic b_clk,
   output logic reset_o
);
   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      b_clk = 1'b0;
      forever #(PERIOD_NS/2) b_clk = ~b_clk;
   end

   // Release on a falling edge, like the rest of the stimulus
   initial begin
      reset_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge b_clk);
      @(negedge b_clk);
      reset_o = 1'b0;
   end

endmodule : tb_clkgen

`default_nettype wire

// ==== include/tb_lfsr.svh ====
`ifndef TB_LFSR_SVH
`define TB_LFSR_SVH

// --------------------
// Random bits
// --------------------

// Fibonacci LFSR, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
   logic fb;
   fb = state[31] ^ state[21] ^ state[1] ^ state[0];
   return {state[30:0], fb};
endfunction

logic [31:0] lfsr_state = 32'h486fd02d;   // Fixed seed

// One step per bit taken, newest bit in bit 0
task automatic take_bits(input int n, output logic [31:0] v);
   v = '0;
   for (int b = 0; b < n; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v          = {v[30:0], lfsr_state[0]};
   end
endtask

`endif

// ==== verif/tb_tart_vis.sv ====
`default_nettype none

module tb_tart_vis;
   timeunit 1ns;
   timeprecision 1ps;
   import tart_pkg::*;

   localparam int ANTENNAS = ANTENNAS_DEF;
   localparam int ACCUM    = ACCUM_DEF;
   localparam int NPAIR    = ANTENNAS*(ANTENNAS-1)/2;
   localparam int PBITS    = (NPAIR > 1) ? $clog2(NPAIR) : 1;
   localparam int BLOCK    = 16;    // Samples per block
   localparam int PREFILL  = 8;     // Fills the delay history
   localparam int DRAIN    = 6;     // Pipeline is four deep
   localparam int GAP_MAX  = 3;     // Two random bits per gap
   localparam int READS    = 6;     // Blocks read back over all tests
   localparam int TEST_CYCLES = 4*(PREFILL + DRAIN) + BLOCK*(1 + (GAP_MAX+1) + 2 + 3)
                              + READS*(2*NPAIR + 1);
   localparam int LIMIT    = 2*TEST_CYCLES + 200;

   logic                   b_clk;
   logic                   reset_i;
   logic                   aq_enable_i;
   logic [DELAY_BITS-1:0]  aq_delay_i;
   logic [ACCUM-1:0]       block_size_i;
   logic [ANTENNAS-1:0]    antenna_i;
   logic                   rd_stb_i;
   logic [PBITS-1:0]       rd_adr_i;
   logic                   release_i;
   logic [ACCUM-1:0]       rd_dat_o;
   logic                   rd_ack_o;
   logic                   available_o;
   logic                   overflow_o;

   // Reference model state
   logic [ANTENNAS-1:0]    hist_m [8];      // Driven bits, index 0 newest
   logic [ACCUM-1:0]       cnt_m  [NPAIR];
   int                     smp_m  = 0;
   int                     delay_m = 0;
   logic [NPAIR*ACCUM-1:0] bank_m [$];      // Full buffers, oldest first
   logic                   ovf_m  = 1'b0;

   int cycle_n = 0;
   int checks_n = 0;
   int errors_n = 0;
   int tests_n = 0;
   int tests_bad_n = 0;
   int err_start = 0;

   `include "tb_lfsr.svh"

   tb_clkgen #(.PERIOD_NS(40), .RESET_CYCLES(10)) i_clkgen (
      .b_clk   (b_clk),
      .reset_o (reset_i)
   );

   tart_vis_top i_tart_vis_top (
      .b_clk(b_clk), .reset_i(reset_i), .aq_enable_i(aq_enable_i),
      .aq_delay_i(aq_delay_i), .block_size_i(block_size_i), .antenna_i(antenna_i),
      .rd_stb_i(rd_stb_i), .rd_adr_i(rd_adr_i), .release_i(release_i),
      .rd_dat_o(rd_dat_o), .rd_ack_o(rd_ack_o), .available_o(available_o),
      .overflow_o(overflow_o)
   );

   // Watchdog
   always @(posedge b_clk) begin
      cycle_n <= cycle_n + 1;
      if (cycle_n >= LIMIT) begin
         $display("timeout after %0d cycles, no block became available", cycle_n);
         $display("Test FAILED");
         $finish;
      end
   end

   // --------------------
   // Model
   // --------------------
   // Pair order (0,1), (0,2), ... row-major
   task automatic model_sample(input logic [ANTENNAS-1:0] smp);
      int                     p;
      logic [NPAIR*ACCUM-1:0] blk;
      p = 0;
      for (int i = 0; i < ANTENNAS-1; i++) begin
         for (int j = i+1; j < ANTENNAS; j++) begin
            if (smp[i] == smp[j]) cnt_m[p] = cnt_m[p] + 1'b1;
            p++;
         end
      end
      smp_m++;
      if (smp_m == BLOCK) begin   // Block closes
         for (int q = 0; q < NPAIR; q++) begin
            blk[q*ACCUM +: ACCUM] = cnt_m[q];
            cnt_m[q]              = '0;
         end
         smp_m = 0;
         if (bank_m.size() < 2) bank_m.push_back(blk);
         else ovf_m = 1'b1;   // Both buffers full, block lost
      end
   endtask

   // --------------------
   // Stimulus
   // --------------------
   task automatic drive_cycle(input logic en, input logic [ANTENNAS-1:0] ant);
      @(negedge b_clk);
      aq_enable_i = en;
      antenna_i   = ant;
      for (int k = 7; k > 0; k--) hist_m[k] = hist_m[k-1];
      hist_m[0] = ant;
      if (en) model_sample(hist_m[delay_m]);   // Bits from d cycles back
   endtask

   task automatic idle_cycles(input int n);
      logic [31:0] r;
      for (int k = 0; k < n; k++) begin
         take_bits(ANTENNAS, r);
         drive_cycle(1'b0, r[ANTENNAS-1:0]);
      end
   endtask

   task automatic run_samples(input int n, input bit gaps);
      logic [31:0] r;
      logic [31:0] g;
      for (int s = 0; s < n; s++) begin
         g = '0;
         if (gaps) take_bits(2, g);
         for (int k = 0; k < int'(g); k++) begin   // Disabled cycles first
            take_bits(ANTENNAS, r);
            drive_cycle(1'b0, r[ANTENNAS-1:0]);
         end
         take_bits(ANTENNAS, r);
         drive_cycle(1'b1, r[ANTENNAS-1:0]);
      end
   endtask

   task automatic set_delay(input int d);
      @(negedge b_clk);
      aq_delay_i = d[DELAY_BITS-1:0];
      delay_m    = d;
   endtask

   // --------------------
   // Checks
   // --------------------
   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      checks_n++;
      if (got !== exp) begin
         errors_n++;
         $display("mismatch %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic wait_available();
      while (available_o !== 1'b1) @(negedge b_clk);   // Watchdog bounds this
   endtask

   task automatic read_block(input logic [NPAIR*ACCUM-1:0] exp);
      for (int p = 0; p < NPAIR; p++) begin
         @(negedge b_clk);
         rd_stb_i = 1'b1;
         rd_adr_i = p[PBITS-1:0];
         @(negedge b_clk);
         rd_stb_i = 1'b0;
         compare_value("rd_ack_o", 32'(rd_ack_o), 32'd1);
         compare_value($sformatf("rd_dat_o[%0d]", p), 32'(rd_dat_o),
                       32'(exp[p*ACCUM +: ACCUM]));
      end
   endtask

   task automatic release_block();
      @(negedge b_clk);
      release_i = 1'b1;
      @(negedge b_clk);
      release_i = 1'b0;
      void'(bank_m.pop_front());
   endtask

   task automatic end_test(input string name);
      tests_n++;
      if (errors_n == err_start) begin
         $display("test %0d %s: pass", tests_n, name);
      end else begin
         tests_bad_n++;
         $display("test %0d %s: fail, %0d errors", tests_n, name, errors_n - err_start);
      end
      err_start = errors_n;
   endtask

   // --------------------
   // Test sequence
   // --------------------
   initial begin
      logic [31:0] r;
      aq_enable_i  = 1'b0;
      aq_delay_i   = '0;
      block_size_i = ACCUM'(BLOCK);
      antenna_i    = '0;
      rd_stb_i     = 1'b0;
      rd_adr_i     = '0;
      release_i    = 1'b0;
      for (int k = 0; k < 8; k++) hist_m[k] = '0;
      for (int p = 0; p < NPAIR; p++) cnt_m[p] = '0;
      wait (reset_i === 1'b0);
      @(negedge b_clk);

      compare_value("available_o", 32'(available_o), 32'd0);
      compare_value("overflow_o", 32'(overflow_o), 32'd0);
      compare_value("rd_ack_o", 32'(rd_ack_o), 32'd0);
      end_test("after reset");

      set_delay(0);
      idle_cycles(PREFILL);
      run_samples(BLOCK, 1'b0);
      idle_cycles(DRAIN);
      wait_available();
      read_block(bank_m[0]);
      release_block();
      compare_value("available_o", 32'(available_o), 32'd0);
      end_test("delay 0, continuous enable");

      r = '0;
      while (r == 0) take_bits(DELAY_BITS, r);   // Nonzero delay
      set_delay(int'(r));
      idle_cycles(PREFILL);
      run_samples(BLOCK, 1'b1);
      idle_cycles(DRAIN);
      wait_available();
      read_block(bank_m[0]);
      release_block();
      end_test($sformatf("delay %0d with enable gaps", delay_m));

      // Two blocks held at once
      idle_cycles(PREFILL);
      run_samples(2*BLOCK, 1'b0);
      idle_cycles(DRAIN);
      wait_available();
      compare_value("overflow_o", 32'(overflow_o), 32'(ovf_m));
      read_block(bank_m[0]);
      release_block();
      compare_value("available_o", 32'(available_o), 32'd1);
      read_block(bank_m[0]);
      release_block();
      compare_value("available_o", 32'(available_o), 32'd0);
      end_test("double buffering");

      // Third block finds both buffers full
      idle_cycles(PREFILL);
      run_samples(3*BLOCK, 1'b0);
      idle_cycles(DRAIN);
      wait_available();
      compare_value("overflow_o", 32'(overflow_o), 32'(ovf_m));
      read_block(bank_m[0]);
      release_block();
      read_block(bank_m[0]);
      release_block();
      compare_value("available_o", 32'(available_o), 32'd0);
      compare_value("overflow_o", 32'(overflow_o), 32'd1);   // Sticky
      end_test("overflow");

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_n, tests_bad_n, checks_n, errors_n);
      if (errors_n == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule : tb_tart_vis

`default_nettype wire

// ==== src.f ====
+incdir+include
design/tart_pkg.sv
design/ax_capture.sv
design/vis_correlate.sv
design/vis_accumulate.sv
design/vis_bank.sv
design/tart_vis_top.sv
verif/tb_clkgen.sv
verif/tb_tart_vis.sv

// ==== Makefile ====
# Verilator build for the visibility path testbench

VERILATOR ?= verilator
FILELIST  ?= src.f
TOP       ?= tb_tart_vis
RTL_TOP   ?= tart_vis_top
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test OK

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --timescale $(TIMESCALE) \
		-f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(FILELIST) $(wildcard design/*.sv verif/*.sv include/*.svh)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
